// File: ant_pkg.sv
`default_nettype none

package ant_pkg;

    // Screen and sprite geometry
    localparam int screen_width  = 160;
    localparam int screen_height = 120;
    localparam int ant_width     = 3;
    localparam int ant_height    = 3;

    // Widths of the record fields and the datapath
    localparam int x_width       = 8;
    localparam int y_width       = 7;
    localparam int fitness_width = 8;
    localparam int id_width      = 4;
    localparam int addr_width    = 8;
    localparam int result_width  = 16;
    localparam int colour_width  = 3;

    // Memory words per ant record
    localparam int field_count   = 4;

    typedef logic [x_width-1:0]       x_t;
    typedef logic [y_width-1:0]       y_t;
    typedef logic [fitness_width-1:0] fitness_t;
    typedef logic [id_width-1:0]      id_t;
    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [result_width-1:0]  result_t;
    typedef logic [colour_width-1:0]  colour_t;

    localparam colour_t colour_ant = colour_t'(4);

    // An ant bounces once its sprite reaches the far edge
    localparam x_t x_limit = x_t'(screen_width - ant_width);
    localparam y_t y_limit = y_t'(screen_height - ant_height);

    typedef enum logic [1:0] {
        mem_read,
        mem_write,
        draw
    } dp_opcode_t;

    typedef enum logic [1:0] {
        field_x       = 2'd0,
        field_y       = 2'd1,
        field_fitness = 2'd2
    } ant_field_t;

    typedef struct packed {
        dp_opcode_t opcode;
        addr_t      addr;
        result_t    wdata;
        x_t         px;
        y_t         py;
        colour_t    colour;
    } dp_instr_t;

    typedef struct packed {
        logic      start;
        dp_instr_t instr;
    } dp_req_t;

    typedef struct packed {
        logic    finished;
        result_t result;
    } dp_rsp_t;

    // Word address of one field of an ant record
    function automatic addr_t rec_addr(id_t id, ant_field_t field);
        return addr_t'(id) * addr_t'(field_count) + addr_t'(field);
    endfunction

endpackage

`default_nettype wire

// File: dp_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module dp_arbiter (
    input  logic             clock,
    input  logic             resetn,
    input  ant_pkg::dp_req_t upd_req,
    input  ant_pkg::dp_req_t drw_req,
    input  ant_pkg::dp_rsp_t dp_rsp,
    output ant_pkg::dp_req_t dp_req,
    output ant_pkg::dp_rsp_t upd_rsp,
    output ant_pkg::dp_rsp_t drw_rsp
);

    typedef enum logic [1:0] {
        own_none,
        own_update,
        own_draw
    } owner_t;

    owner_t             owner;
    logic               hold;
    logic               upd_start_q;
    logic               drw_start_q;
    logic               upd_rise;
    logic               drw_rise;
    logic               pend_upd;
    logic               pend_drw;
    logic               grant_upd;
    logic               grant_drw;
    ant_pkg::dp_instr_t grant_instr;
    ant_pkg::dp_instr_t cur_instr;
    ant_pkg::dp_instr_t pend_instr;

    // A transaction is offered only in its issue cycle
    assign upd_rise = upd_req.start && !upd_start_q;
    assign drw_rise = drw_req.start && !drw_start_q;

    // Pending requests count as a start still held high; update has priority
    always_comb begin
        grant_upd = (owner == own_none) && (upd_rise || pend_upd);
        grant_drw = (owner == own_none) && !(upd_rise || pend_upd) && (drw_rise || pend_drw);
        if (grant_upd) begin
            grant_instr = pend_upd ? pend_instr : upd_req.instr;
        end else begin
            grant_instr = pend_drw ? pend_instr : drw_req.instr;
        end
    end

    // Grant cycle passes the request straight through, hold cycle replays it
    always_comb begin
        if (owner == own_none) begin
            dp_req.start = grant_upd || grant_drw;
            dp_req.instr = grant_instr;
        end else begin
            dp_req.start = hold;
            dp_req.instr = cur_instr;
        end
    end

    assign upd_rsp.finished = dp_rsp.finished && (owner == own_update);
    assign upd_rsp.result   = dp_rsp.result;
    assign drw_rsp.finished = dp_rsp.finished && (owner == own_draw);
    assign drw_rsp.result   = dp_rsp.result;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            owner       <= own_none;
            hold        <= 1'b0;
            pend_upd    <= 1'b0;
            pend_drw    <= 1'b0;
            upd_start_q <= 1'b0;
            drw_start_q <= 1'b0;
        end else begin
            upd_start_q <= upd_req.start;
            drw_start_q <= drw_req.start;
            hold        <= grant_upd || grant_drw;
            if (grant_upd) begin
                owner    <= own_update;
                pend_upd <= 1'b0;
            end else if (grant_drw) begin
                owner    <= own_draw;
                pend_drw <= 1'b0;
            end else if (dp_rsp.finished) begin
                owner <= own_none;
            end
            // Loser of this cycle waits for the next release
            if (upd_rise && !grant_upd) begin
                pend_upd <= 1'b1;
            end
            if (drw_rise && !grant_drw) begin
                pend_drw <= 1'b1;
            end
        end
    end

    // Only one requester can be pending at any time
    always_ff @(posedge clock) begin
        if (grant_upd || grant_drw) begin
            cur_instr <= grant_instr;
        end
        if (upd_rise && !grant_upd) begin
            pend_instr <= upd_req.instr;
        end else if (drw_rise && !grant_drw) begin
            pend_instr <= drw_req.instr;
        end
    end

    finished_needs_owner: assert property (
        @(posedge clock) disable iff (!resetn) dp_rsp.finished |-> owner != own_none
    ) else $error("datapath finished with no transaction in flight");

endmodule

`default_nettype wire

// File: ant_draw.sv
`default_nettype none
`timescale 1ns/100ps

module ant_draw (
    input  logic             clock,
    input  logic             resetn,
    input  logic             start,
    input  ant_pkg::id_t     id,
    input  ant_pkg::dp_rsp_t rsp,
    output ant_pkg::dp_req_t req,
    output logic             finished
);

    typedef enum logic [3:0] {
        st_standby,
        st_ld_x_issue,
        st_ld_x_hold,
        st_ld_x_wait,
        st_ld_y_issue,
        st_ld_y_hold,
        st_ld_y_wait,
        st_draw_issue,
        st_draw_hold,
        st_draw_wait
    } state_t;

    state_t        state;
    ant_pkg::x_t   x;
    ant_pkg::y_t   y;
    ant_pkg::x_t   col;
    ant_pkg::y_t   row;

    assign finished = (state == st_standby);

    always_comb begin
        req = '0;
        req.start = state inside {st_ld_x_issue, st_ld_x_hold, st_ld_y_issue,
                                  st_ld_y_hold, st_draw_issue, st_draw_hold};
        case (state)
            st_ld_x_issue, st_ld_x_hold: begin
                req.instr.opcode = ant_pkg::mem_read;
                req.instr.addr   = ant_pkg::rec_addr(id, ant_pkg::field_x);
            end
            st_ld_y_issue, st_ld_y_hold: begin
                req.instr.opcode = ant_pkg::mem_read;
                req.instr.addr   = ant_pkg::rec_addr(id, ant_pkg::field_y);
            end
            default: begin
                req.instr.opcode = ant_pkg::draw;
                req.instr.px     = x + col;
                req.instr.py     = y + row;
                req.instr.colour = ant_pkg::colour_ant;
            end
        endcase
    end

    // Stored position is the sprite centre, keep its top left corner
    always_ff @(posedge clock) begin
        if (rsp.finished && state == st_ld_x_wait) begin
            x <= rsp.result[ant_pkg::x_width-1:0] - ant_pkg::x_t'(1);
        end
        if (rsp.finished && state == st_ld_y_wait) begin
            y <= rsp.result[ant_pkg::y_width-1:0] - ant_pkg::y_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_standby;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                st_standby:    if (start) state <= st_ld_x_issue;
                st_ld_x_issue: state <= st_ld_x_hold;
                st_ld_x_hold:  state <= st_ld_x_wait;
                st_ld_x_wait:  if (rsp.finished) state <= st_ld_y_issue;
                st_ld_y_issue: state <= st_ld_y_hold;
                st_ld_y_hold:  state <= st_ld_y_wait;
                st_ld_y_wait:  if (rsp.finished) state <= st_draw_issue;
                st_draw_issue: state <= st_draw_hold;
                st_draw_hold:  state <= st_draw_wait;
                st_draw_wait: begin
                    // Raster order, columns fastest
                    if (rsp.finished) begin
                        if (col == ant_pkg::x_t'(ant_pkg::ant_width - 1)) begin
                            col <= '0;
                            if (row == ant_pkg::y_t'(ant_pkg::ant_height - 1)) begin
                                row   <= '0;
                                state <= st_standby;
                            end else begin
                                row   <= row + ant_pkg::y_t'(1);
                                state <= st_draw_issue;
                            end
                        end else begin
                            col   <= col + ant_pkg::x_t'(1);
                            state <= st_draw_issue;
                        end
                    end
                end
                default: state <= st_standby;
            endcase
        end
    end

    col_in_sprite: assert property (
        @(posedge clock) disable iff (!resetn) col < ant_pkg::x_t'(ant_pkg::ant_width)
    ) else $error("sprite column counter out of range");

endmodule

`default_nettype wire

// File: ant_update.sv
`default_nettype none
`timescale 1ns/100ps

module ant_update (
    input  logic             clock,
    input  logic             resetn,
    input  logic             start,
    input  ant_pkg::id_t     id,
    input  ant_pkg::dp_rsp_t rsp,
    output ant_pkg::dp_req_t req,
    output logic             finished
);

    typedef enum logic [4:0] {
        st_standby,
        st_ld_x_issue,
        st_ld_x_hold,
        st_ld_x_wait,
        st_ld_y_issue,
        st_ld_y_hold,
        st_ld_y_wait,
        st_ld_fit_issue,
        st_ld_fit_hold,
        st_ld_fit_wait,
        st_move,
        st_st_x_issue,
        st_st_x_hold,
        st_st_x_wait,
        st_st_y_issue,
        st_st_y_hold,
        st_st_y_wait,
        st_st_fit_issue,
        st_st_fit_hold,
        st_st_fit_wait
    } state_t;

    state_t              state;
    ant_pkg::x_t         x;
    ant_pkg::y_t         y;
    ant_pkg::fitness_t   fitness;
    ant_pkg::x_t         dx;
    ant_pkg::y_t         dy;
    ant_pkg::x_t         new_x;
    ant_pkg::y_t         new_y;
    logic                flip_x;
    logic                flip_y;
    logic                storing;
    logic                waiting;
    ant_pkg::ant_field_t field;

    assign finished = (state == st_standby);

    assign new_x  = x + dx;
    assign new_y  = y + dy;
    assign flip_x = (new_x == '0) || (new_x >= ant_pkg::x_limit);
    assign flip_y = (new_y == '0) || (new_y >= ant_pkg::y_limit);

    assign storing = state inside {st_st_x_issue, st_st_x_hold, st_st_y_issue,
                                   st_st_y_hold, st_st_fit_issue, st_st_fit_hold};
    assign waiting = state inside {st_ld_x_wait, st_ld_y_wait, st_ld_fit_wait,
                                   st_st_x_wait, st_st_y_wait, st_st_fit_wait};

    // Record field addressed by the current transaction
    always_comb begin
        case (state)
            st_ld_y_issue, st_ld_y_hold, st_st_y_issue, st_st_y_hold:
                field = ant_pkg::field_y;
            st_ld_fit_issue, st_ld_fit_hold, st_st_fit_issue, st_st_fit_hold:
                field = ant_pkg::field_fitness;
            default:
                field = ant_pkg::field_x;
        endcase
    end

    always_comb begin
        req = '0;
        req.start = storing || state inside {st_ld_x_issue, st_ld_x_hold, st_ld_y_issue,
                                             st_ld_y_hold, st_ld_fit_issue, st_ld_fit_hold};
        req.instr.addr = ant_pkg::rec_addr(id, field);
        if (storing) begin
            req.instr.opcode = ant_pkg::mem_write;
            case (field)
                ant_pkg::field_y:       req.instr.wdata = ant_pkg::result_t'(y);
                ant_pkg::field_fitness: req.instr.wdata = ant_pkg::result_t'(fitness);
                default:                req.instr.wdata = ant_pkg::result_t'(x);
            endcase
        end else begin
            req.instr.opcode = ant_pkg::mem_read;
        end
    end

    always_ff @(posedge clock) begin
        if (rsp.finished && state == st_ld_x_wait) begin
            x <= rsp.result[ant_pkg::x_width-1:0];
        end
        if (rsp.finished && state == st_ld_y_wait) begin
            y <= rsp.result[ant_pkg::y_width-1:0];
        end
        if (rsp.finished && state == st_ld_fit_wait) begin
            fitness <= rsp.result[ant_pkg::fitness_width-1:0];
        end
        if (state == st_move) begin
            x <= new_x;
            y <= new_y;
        end
    end

    // Velocity is shared by all ants and kept between operations
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_standby;
            dx    <= ant_pkg::x_t'(1);
            dy    <= ant_pkg::y_t'(1);
        end else begin
            case (state)
                st_standby:      if (start) state <= st_ld_x_issue;
                st_ld_x_issue:   state <= st_ld_x_hold;
                st_ld_x_hold:    state <= st_ld_x_wait;
                st_ld_x_wait:    if (rsp.finished) state <= st_ld_y_issue;
                st_ld_y_issue:   state <= st_ld_y_hold;
                st_ld_y_hold:    state <= st_ld_y_wait;
                st_ld_y_wait:    if (rsp.finished) state <= st_ld_fit_issue;
                st_ld_fit_issue: state <= st_ld_fit_hold;
                st_ld_fit_hold:  state <= st_ld_fit_wait;
                st_ld_fit_wait:  if (rsp.finished) state <= st_move;
                st_move: begin
                    // Bounce off the edges for the next move
                    if (flip_x) begin
                        dx <= -dx;
                    end
                    if (flip_y) begin
                        dy <= -dy;
                    end
                    state <= st_st_x_issue;
                end
                st_st_x_issue:   state <= st_st_x_hold;
                st_st_x_hold:    state <= st_st_x_wait;
                st_st_x_wait:    if (rsp.finished) state <= st_st_y_issue;
                st_st_y_issue:   state <= st_st_y_hold;
                st_st_y_hold:    state <= st_st_y_wait;
                st_st_y_wait:    if (rsp.finished) state <= st_st_fit_issue;
                st_st_fit_issue: state <= st_st_fit_hold;
                st_st_fit_hold:  state <= st_st_fit_wait;
                st_st_fit_wait:  if (rsp.finished) state <= st_standby;
                default:         state <= st_standby;
            endcase
        end
    end

    no_start_while_waiting: assert property (
        @(posedge clock) disable iff (!resetn) waiting |-> !req.start
    ) else $error("update request start high while waiting for finished");

    unit_velocity: assert property (
        @(posedge clock) disable iff (!resetn)
        (dx == ant_pkg::x_t'(1) || dx == '1) && (dy == ant_pkg::y_t'(1) || dy == '1)
    ) else $error("velocity magnitude is not 1");

endmodule

`default_nettype wire

// File: ant_engine.sv
`default_nettype none
`timescale 1ns/100ps

module ant_engine (
    input  logic             clock,
    input  logic             resetn,
    input  logic             update_start,
    input  logic             draw_start,
    input  ant_pkg::id_t     id,
    input  ant_pkg::dp_rsp_t dp_rsp,
    output ant_pkg::dp_req_t dp_req,
    output logic             update_finished,
    output logic             draw_finished
);

    ant_pkg::dp_req_t upd_req;
    ant_pkg::dp_req_t drw_req;
    ant_pkg::dp_rsp_t upd_rsp;
    ant_pkg::dp_rsp_t drw_rsp;

    ant_update u_update (
        .clock    (clock),
        .resetn   (resetn),
        .start    (update_start),
        .id       (id),
        .rsp      (upd_rsp),
        .req      (upd_req),
        .finished (update_finished)
    );

    ant_draw u_draw (
        .clock    (clock),
        .resetn   (resetn),
        .start    (draw_start),
        .id       (id),
        .rsp      (drw_rsp),
        .req      (drw_req),
        .finished (draw_finished)
    );

    // Both sequencers share the single datapath port
    dp_arbiter u_arbiter (
        .clock   (clock),
        .resetn  (resetn),
        .upd_req (upd_req),
        .drw_req (drw_req),
        .dp_rsp  (dp_rsp),
        .dp_req  (dp_req),
        .upd_rsp (upd_rsp),
        .drw_rsp (drw_rsp)
    );

endmodule

`default_nettype wire

// File: tb_ant_engine.sv
`default_nettype none
`timescale 1ns/100ps

module tb_ant_engine;

    // One line of the trace file
    typedef struct packed {
        logic       do_update;
        logic       do_draw;
        logic [7:0] id;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] fit;
        logic [7:0] ex;
        logic [7:0] ey;
        logic [7:0] epx;
        logic [7:0] epy;
    } test_t;

    logic             clock;
    logic             resetn;
    logic             update_start;
    logic             draw_start;
    ant_pkg::id_t     id;
    ant_pkg::dp_rsp_t dp_rsp;
    ant_pkg::dp_req_t dp_req;
    logic             update_finished;
    logic             draw_finished;

    test_t              tests[$];
    logic [15:0]        mem [0:255];
    ant_pkg::dp_instr_t trans_log[$];
    ant_pkg::dp_instr_t cur_instr;
    logic               in_start;
    logic               busy;
    int                 start_cycles;
    int                 wait_cnt;
    int                 error_count;
    int                 pass_count;
    int                 fail_count;
    int                 cycle_count = 0;
    int                 cycle_limit;
    int                 dx_m;
    int                 dy_m;
    int unsigned        lcg_state;

    ant_engine dut (
        .clock           (clock),
        .resetn          (resetn),
        .update_start    (update_start),
        .draw_start      (draw_start),
        .id              (id),
        .dp_rsp          (dp_rsp),
        .dp_req          (dp_req),
        .update_finished (update_finished),
        .draw_finished   (draw_finished)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles, an operation never finished",
                     cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    // Memory and screen model called once per cycle at the falling edge
    task automatic serve_datapath();
        dp_rsp.finished = 1'b0;
        if (!resetn) begin
            in_start = 1'b0;
            busy     = 1'b0;
            wait_cnt = 0;
        end else if (dp_req.start) begin
            if (!in_start) begin
                if (busy) begin
                    $display("Datapath start raised while another transaction awaits finished");
                    error_count++;
                end
                in_start     = 1'b1;
                busy         = 1'b1;
                start_cycles = 0;
                cur_instr    = dp_req.instr;
            end else if (dp_req.instr != cur_instr) begin
                $display("Datapath instruction changed while start was held");
                error_count++;
            end
            start_cycles++;
        end else if (in_start) begin
            in_start = 1'b0;
            if (start_cycles != 2) begin
                $display("Datapath start held for %0d cycles instead of 2", start_cycles);
                error_count++;
            end
            wait_cnt = 1 + int'(next_random() % 4);
        end else if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                busy            = 1'b0;
                dp_rsp.finished = 1'b1;
                dp_rsp.result   = 16'h0;
                if (cur_instr.opcode == ant_pkg::mem_read) begin
                    dp_rsp.result = mem[cur_instr.addr];
                end
                if (cur_instr.opcode == ant_pkg::mem_write) begin
                    mem[cur_instr.addr] = cur_instr.wdata;
                end
                trans_log.push_back(cur_instr);
            end
        end
    endtask

    task automatic tick();
        @(negedge clock);
        serve_datapath();
    endtask

    task automatic load_trace();
        int    fd;
        int    rc;
        int    v [8];
        string line;
        string cmd;
        test_t t;
        fd = $fopen("ant_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open ant_trace.txt, no tests to run");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d", cmd, v[0], v[1], v[2],
                                 v[3], v[4], v[5], v[6], v[7]);
                    if (rc == 9) begin
                        t.do_update = (cmd == "update" || cmd == "both");
                        t.do_draw   = (cmd == "draw" || cmd == "both");
                        t.id  = 8'(v[0]);
                        t.x   = 8'(v[1]);
                        t.y   = 8'(v[2]);
                        t.fit = 8'(v[3]);
                        t.ex  = 8'(v[4]);
                        t.ey  = 8'(v[5]);
                        t.epx = 8'(v[6]);
                        t.epy = 8'(v[7]);
                        tests.push_back(t);
                    end else begin
                        $display("Malformed trace line: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic string command_name(input test_t t);
        if (t.do_update && t.do_draw) begin
            return "both";
        end else if (t.do_update) begin
            return "update";
        end
        return "draw";
    endfunction

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Idle engine after reset
    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        repeat (4) begin
            tick();
            check_value("update_finished", 32'(update_finished), 32'(1));
            check_value("draw_finished", 32'(draw_finished), 32'(1));
            check_value("dp_req.start", 32'(dp_req.start), 32'(0));
        end
        report_test("Test 0 reset", errors_before);
    endtask

    // Shared velocity model that bounces at the edges after the move
    task automatic check_velocity_model(input test_t t);
        int mx;
        int my;
        mx = (int'(t.x) + dx_m + 256) % 256;
        my = (int'(t.y) + dy_m + 128) % 128;
        check_value("trace new x", 32'(t.ex), 32'(mx));
        check_value("trace new y", 32'(t.ey), 32'(my));
        if (mx == 0 || mx >= ant_pkg::screen_width - ant_pkg::ant_width) begin
            dx_m = -dx_m;
        end
        if (my == 0 || my >= ant_pkg::screen_height - ant_pkg::ant_height) begin
            dy_m = -dy_m;
        end
    endtask

    task automatic check_transactions(input test_t t);
        ant_pkg::dp_instr_t tr;
        int base;
        int field;
        int n_read;
        int n_write;
        int n_draw;
        int wdata_exp [3];
        base         = int'(t.id) * ant_pkg::field_count;
        n_read       = 0;
        n_write      = 0;
        n_draw       = 0;
        wdata_exp[0] = int'(t.ex);
        wdata_exp[1] = int'(t.ey);
        wdata_exp[2] = int'(t.fit);
        foreach (trans_log[i]) begin
            tr = trans_log[i];
            case (tr.opcode)
                ant_pkg::mem_read: begin
                    // With both running, the update's three reads are served first
                    field = (t.do_update && n_read >= 3) ? n_read - 3 : n_read;
                    check_value("read addr", 32'(tr.addr), 32'(base + field));
                    n_read++;
                end
                ant_pkg::mem_write: begin
                    if (!t.do_draw) begin
                        check_value("reads before write", 32'(n_read), 32'(3));
                    end
                    if (n_write < 3) begin
                        check_value("write addr", 32'(tr.addr), 32'(base + n_write));
                        check_value("write data", 32'(tr.wdata), 32'(wdata_exp[n_write]));
                    end
                    n_write++;
                end
                default: begin
                    check_value("draw px", 32'(tr.px),
                                32'((int'(t.epx) + n_draw % ant_pkg::ant_width) % 256));
                    check_value("draw py", 32'(tr.py),
                                32'((int'(t.epy) + n_draw / ant_pkg::ant_width) % 128));
                    check_value("draw colour", 32'(tr.colour), 32'(4));
                    n_draw++;
                end
            endcase
        end
        check_value("read count", 32'(n_read),
                    32'(3 * int'(t.do_update) + 2 * int'(t.do_draw)));
        check_value("write count", 32'(n_write), 32'(3 * int'(t.do_update)));
        check_value("draw count", 32'(n_draw), 32'(9 * int'(t.do_draw)));
    endtask

    task automatic run_test(input int n);
        test_t t;
        int    errors_before;
        int    base;
        t             = tests[n];
        errors_before = error_count;
        base          = int'(t.id) * ant_pkg::field_count;
        tick();
        id            = ant_pkg::id_t'(t.id);
        mem[base]     = 16'(t.x);
        mem[base + 1] = 16'(t.y);
        mem[base + 2] = 16'(t.fit);
        trans_log.delete();
        update_start  = t.do_update;
        draw_start    = t.do_draw;
        tick();
        update_start  = 1'b0;
        draw_start    = 1'b0;
        if (t.do_update) begin
            check_value("update_finished", 32'(update_finished), 32'(0));
        end
        if (t.do_draw) begin
            check_value("draw_finished", 32'(draw_finished), 32'(0));
        end
        while (!(update_finished && draw_finished)) begin
            tick();
        end
        if (t.do_update) begin
            check_velocity_model(t);
        end
        check_transactions(t);
        report_test($sformatf("Test %0d %s id %0d", n + 1, command_name(t), t.id),
                    errors_before);
    endtask

    initial begin
        clock        = 1'b0;
        resetn       = 1'b0;
        update_start = 1'b0;
        draw_start   = 1'b0;
        id           = '0;
        dp_rsp       = '0;
        lcg_state    = 19;
        dx_m         = 1;
        dy_m         = 1;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), ~8'(i)};
        end
        load_trace();
        cycle_limit = (tests.size() + 1) * 200;
        repeat (5) tick();
        resetn = 1'b1;
        check_reset_state();
        foreach (tests[n]) begin
            run_test(n);
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ant_trace.txt
# command id x y fitness new_x new_y first_px first_py, all decimal
# new_x and new_y apply to update and both, first_px and first_py to draw and both
update 3 80 60 90 81 61 0 0
update 5 156 40 17 157 41 0 0
update 5 157 41 17 156 42 0 0
draw 7 50 30 9 0 0 49 29
both 2 100 70 33 99 71 99 70
draw 0 1 1 0 0 0 0 0
update 15 1 116 255 0 117 0 0
update 15 0 117 255 1 116 0 0
both 9 20 20 128 21 19 19 18

// File: vlog.f
ant_pkg.sv
dp_arbiter.sv
ant_draw.sv
ant_update.sv
ant_engine.sv
tb_ant_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build the ant engine testbench with Verilator, run it and scan the log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_ant_engine \
    -f vlog.f -o tb_ant_engine \
    && ./obj_dir/tb_ant_engine > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Done: errors found" sim.log \
    || { echo "Simulation failed, see sim.log"; exit 1; }
